//--- cache_axi_bridge.f
logic/cache_axi_pkg.sv
logic/refill_arbiter.sv
logic/axi_read_engine.sv
logic/axi_write_engine.sv
logic/cache_axi_bridge.sv
test/cache_axi_bridge_assertions.sv
test/cache_axi_bridge_tb.sv

//--- logic/axi_read_engine.sv
`default_nettype none

module axi_read_engine import cache_axi_pkg::*; (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              rd_go,
    input  rd_req_t           rd,
    input  logic [id_w-1:0]   rd_id,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rd_idle,
    output logic              ret_pulse,
    output logic [line_w-1:0] ret_line,
    output logic [id_w-1:0]   ret_id,
    output axi_ar_t           ar,
    output logic              arvalid,
    output logic              rready
);

    typedef enum logic [1:0] {
        rd_s_idle,
        rd_s_addr,
        rd_s_collect,
        rd_s_return
    } rd_state_t;

    rd_state_t         state;
    logic [beat_w-1:0] beat_cnt;
    rd_req_t           req_q;
    logic [id_w-1:0]   id_q;
    logic [line_w-1:0] line_q;
    logic              is_line;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= rd_s_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                rd_s_idle: begin
                    if (rd_go) begin
                        state    <= rd_s_addr;
                        beat_cnt <= '0;
                    end
                end
                rd_s_addr: begin
                    if (arready) begin
                        state <= rd_s_collect;
                    end
                end
                rd_s_collect: begin
                    if (rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r.last) begin
                            state <= rd_s_return;
                        end
                    end
                end
                default: begin
                    // one cycle of return, then back to idle
                    state <= rd_s_idle;
                end
            endcase
        end
    end

    // request and line storage
    always_ff @(posedge aclk) begin
        if (state == rd_s_idle && rd_go) begin
            req_q  <= rd;
            id_q   <= rd_id;
            line_q <= '0;
        end else if (state == rd_s_collect && rvalid) begin
            line_q[beat_cnt*data_w +: data_w] <= r.data;
        end
    end

    assign is_line = (req_q.kind == type_line);

    always_comb begin
        ar.id   = id_q;
        ar.addr = issue_addr(req_q.kind, req_q.addr);
        ar.len  = is_line ? 8'(line_beats - 1) : 8'd0;
        ar.size = is_line ? line_size : req_q.kind;
    end

    assign arvalid   = (state == rd_s_addr);
    assign rready    = (state == rd_s_collect);
    assign rd_idle   = (state == rd_s_idle);
    assign ret_pulse = (state == rd_s_return);
    assign ret_line  = line_q;
    assign ret_id    = id_q;

endmodule

`default_nettype wire

//--- logic/axi_write_engine.sv
`default_nettype none

module axi_write_engine import cache_axi_pkg::*; (
    input  logic    aclk,
    input  logic    rst_n,
    input  logic    data_wr_req,
    input  wr_req_t data_wr,
    input  logic    awready,
    input  logic    wready,
    input  logic    bvalid,
    output logic    wr_idle,
    output axi_ar_t aw,
    output logic    awvalid,
    output axi_w_t  w,
    output logic    wvalid,
    output logic    bready
);

    typedef enum logic [1:0] {
        wr_s_idle,
        wr_s_addr,
        wr_s_data,
        wr_s_resp
    } wr_state_t;

    wr_state_t         state;
    logic [beat_w-1:0] beat_cnt;
    wr_req_t           req_q;
    logic              is_line;
    logic              last_beat;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= wr_s_idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                wr_s_idle: begin
                    if (data_wr_req) begin
                        state    <= wr_s_addr;
                        beat_cnt <= '0;
                    end
                end
                wr_s_addr: begin
                    if (awready) begin
                        state <= wr_s_data;
                    end
                end
                wr_s_data: begin
                    if (wready) begin
                        if (last_beat) begin
                            state <= wr_s_resp;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        state <= wr_s_idle;
                    end
                end
            endcase
        end
    end

    // request is taken only while idle
    always_ff @(posedge aclk) begin
        if (state == wr_s_idle && data_wr_req) begin
            req_q <= data_wr;
        end
    end

    assign is_line   = (req_q.kind == type_line);
    assign last_beat = !is_line || (beat_cnt == beat_w'(line_beats - 1));

    always_comb begin
        aw.id   = id_data;
        aw.addr = issue_addr(req_q.kind, req_q.addr);
        aw.len  = is_line ? 8'(line_beats - 1) : 8'd0;
        aw.size = is_line ? line_size : req_q.kind;
    end

    // words leave in ascending order, full strobes for lines
    always_comb begin
        w.data = req_q.data[beat_cnt*data_w +: data_w];
        w.strb = is_line ? '1 : req_q.strb;
        w.last = last_beat;
    end

    assign wr_idle = (state == wr_s_idle);
    assign awvalid = (state == wr_s_addr);
    assign wvalid  = (state == wr_s_data);
    assign bready  = (state == wr_s_resp);

endmodule

`default_nettype wire

//--- logic/cache_axi_bridge.sv
`default_nettype none

module cache_axi_bridge import cache_axi_pkg::*; (
    input  logic              aclk,
    input  logic              rst_n,
    // instruction client
    input  logic              inst_rd_req,
    input  rd_req_t           inst_rd,
    output logic              inst_rd_rdy,
    output logic              inst_ret_valid,
    output logic [line_w-1:0] inst_ret_data,
    // data client
    input  logic              data_rd_req,
    input  rd_req_t           data_rd,
    output logic              data_rd_rdy,
    output logic              data_ret_valid,
    output logic [line_w-1:0] data_ret_data,
    input  logic              data_wr_req,
    input  wr_req_t           data_wr,
    output logic              data_wr_rdy,
    // AXI master
    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rready,
    output axi_ar_t           aw,
    output logic              awvalid,
    input  logic              awready,
    output axi_w_t            w,
    output logic              wvalid,
    input  logic              wready,
    input  logic              bvalid,
    output logic              bready
);

    logic              rd_go;
    rd_req_t           rd;
    logic [id_w-1:0]   rd_id;
    logic              rd_idle;
    logic              ret_pulse;
    logic [line_w-1:0] ret_line;
    logic [id_w-1:0]   ret_id;
    logic              wr_idle;

    refill_arbiter refill_arbiter_inst (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .inst_rd_req    (inst_rd_req),
        .data_rd_req    (data_rd_req),
        .inst_rd        (inst_rd),
        .data_rd        (data_rd),
        .rd_idle        (rd_idle),
        .ret_pulse      (ret_pulse),
        .ret_line       (ret_line),
        .ret_id         (ret_id),
        .wr_idle        (wr_idle),
        .inst_rd_rdy    (inst_rd_rdy),
        .data_rd_rdy    (data_rd_rdy),
        .rd_go          (rd_go),
        .rd             (rd),
        .rd_id          (rd_id),
        .inst_ret_valid (inst_ret_valid),
        .data_ret_valid (data_ret_valid),
        .inst_ret_data  (inst_ret_data),
        .data_ret_data  (data_ret_data)
    );

    axi_read_engine axi_read_engine_inst (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .rd_go     (rd_go),
        .rd        (rd),
        .rd_id     (rd_id),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rd_idle   (rd_idle),
        .ret_pulse (ret_pulse),
        .ret_line  (ret_line),
        .ret_id    (ret_id),
        .ar        (ar),
        .arvalid   (arvalid),
        .rready    (rready)
    );

    // write engine idle doubles as the write-side ready
    axi_write_engine axi_write_engine_inst (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .data_wr_req (data_wr_req),
        .data_wr     (data_wr),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .wr_idle     (wr_idle),
        .aw          (aw),
        .awvalid     (awvalid),
        .w           (w),
        .wvalid      (wvalid),
        .bready      (bready)
    );

    assign data_wr_rdy = wr_idle;

endmodule

`default_nettype wire

//--- logic/cache_axi_pkg.sv
`default_nettype none

package cache_axi_pkg;

    // bus and line geometry
    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int line_w     = 128;
    localparam int line_beats = 4;
    localparam int id_w       = 4;
    localparam int beat_w     = $clog2(line_beats);

    // request type codes, single-beat codes double as axsize
    localparam logic [2:0] type_byte = 3'd0;
    localparam logic [2:0] type_half = 3'd1;
    localparam logic [2:0] type_word = 3'd2;
    localparam logic [2:0] type_line = 3'd4;

    // size of each beat in a line burst
    localparam logic [2:0] line_size = 3'd2;

    localparam logic [id_w-1:0] id_inst = 4'd0;
    localparam logic [id_w-1:0] id_data = 4'd1;

    localparam logic [1:0] burst_incr = 2'd1;

    typedef logic [2:0] req_type_t;

    // cache-side read request
    typedef struct packed {
        req_type_t         kind;
        logic [addr_w-1:0] addr;
    } rd_req_t;

    // cache-side write request, strb only matters for single writes
    typedef struct packed {
        req_type_t         kind;
        logic [addr_w-1:0] addr;
        logic [3:0]        strb;
        logic [line_w-1:0] data;
    } wr_req_t;

    // address channel, shared by AR and AW
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
    } axi_ar_t;

    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [data_w-1:0] data;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [data_w-1:0]   data;
        logic [data_w/8-1:0] strb;
        logic                last;
    } axi_w_t;

    // lines go out at the 16-byte boundary, singles as given
    function automatic logic [addr_w-1:0] issue_addr(req_type_t kind, logic [addr_w-1:0] addr);
        logic [addr_w-1:0] result;
        result = addr;
        if (kind == type_line) begin
            result[$clog2(line_w/8)-1:0] = '0;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- logic/refill_arbiter.sv
`default_nettype none

module refill_arbiter import cache_axi_pkg::*; (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              inst_rd_req,
    input  logic              data_rd_req,
    input  rd_req_t           inst_rd,
    input  rd_req_t           data_rd,
    input  logic              rd_idle,
    input  logic              ret_pulse,
    input  logic [line_w-1:0] ret_line,
    input  logic [id_w-1:0]   ret_id,
    input  logic              wr_idle,
    output logic              inst_rd_rdy,
    output logic              data_rd_rdy,
    output logic              rd_go,
    output rd_req_t           rd,
    output logic [id_w-1:0]   rd_id,
    output logic              inst_ret_valid,
    output logic              data_ret_valid,
    output logic [line_w-1:0] inst_ret_data,
    output logic [line_w-1:0] data_ret_data
);

    logic              inst_acc;
    logic              data_acc;
    logic [line_w-1:0] inst_line_q;
    logic [line_w-1:0] data_line_q;

    // data has priority; data reads also wait for the write engine
    assign inst_rd_rdy = rd_idle && !data_rd_req;
    assign data_rd_rdy = rd_idle && wr_idle;

    assign inst_acc = inst_rd_req && inst_rd_rdy;
    assign data_acc = data_rd_req && data_rd_rdy;

    assign rd_go = inst_acc || data_acc;
    assign rd    = data_acc ? data_rd : inst_rd;
    assign rd_id = data_acc ? id_data : id_inst;

    // steer the return to its owner
    assign inst_ret_valid = ret_pulse && (ret_id == id_inst);
    assign data_ret_valid = ret_pulse && (ret_id == id_data);

    // each client keeps seeing its last line after the pulse
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            inst_line_q <= '0;
            data_line_q <= '0;
        end else begin
            if (inst_ret_valid) begin
                inst_line_q <= ret_line;
            end
            if (data_ret_valid) begin
                data_line_q <= ret_line;
            end
        end
    end

    assign inst_ret_data = inst_ret_valid ? ret_line : inst_line_q;
    assign data_ret_data = data_ret_valid ? ret_line : data_line_q;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the run from its log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cache_axi_bridge_tb \
    -f cache_axi_bridge.f \
    -o sim_cache_axi_bridge

# assertion errors are counted by the testbench, so the run must not stop at the first one
./obj_dir/sim_cache_axi_bridge +verilator+error+limit+1000 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0

//--- test/cache_axi_bridge_assertions.sv
`default_nettype none

module cache_axi_bridge_assertions import cache_axi_pkg::*; (
    input logic    aclk,
    input logic    rst_n,
    input axi_ar_t ar,
    input logic    arvalid,
    input logic    arready,
    input logic    rready,
    input axi_ar_t aw,
    input logic    awvalid,
    input logic    awready,
    input axi_w_t  w,
    input logic    wvalid,
    input logic    wready,
    input logic    bvalid,
    input logic    bready,
    input logic    inst_ret_valid,
    input logic    data_ret_valid,
    input logic    inst_rd_rdy,
    input logic    data_rd_rdy,
    input logic    data_wr_req,
    input logic    data_wr_rdy
);

    int unsigned fail_count = 0;
    logic [7:0]  aw_len_q;
    logic [7:0]  w_beat;
    logic        write_open;

    // burst length and beat position of the current write, plus write-in-progress
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            aw_len_q   <= '0;
            w_beat     <= '0;
            write_open <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_len_q <= aw.len;
                w_beat   <= '0;
            end else if (wvalid && wready) begin
                w_beat <= w_beat + 1'b1;
            end
            if (data_wr_req && data_wr_rdy) begin
                write_open <= 1'b1;
            end else if (bvalid && bready) begin
                write_open <= 1'b0;
            end
        end
    end

    ar_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin $error("AR dropped or changed before arready"); fail_count++; end

    aw_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin $error("AW dropped or changed before awready"); fail_count++; end

    w_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin $error("W dropped or changed before wready"); fail_count++; end

    ret_one_cycle: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_ret_valid || data_ret_valid |=> !inst_ret_valid && !data_ret_valid)
        else begin $error("return pulse longer than one cycle"); fail_count++; end

    wlast_final: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid |-> (w.last == (w_beat == aw_len_q)))
        else begin $error("wlast does not match the final beat"); fail_count++; end

    // data reads stay behind an open write
    read_after_write: assert property (@(posedge aclk) disable iff (!rst_n)
        write_open |-> !data_rd_rdy)
        else begin $error("data_rd_rdy high while a write is open"); fail_count++; end

    reset_values: assert property (@(posedge aclk)
        !rst_n |=> !arvalid && !awvalid && !wvalid && !rready && !bready
            && !inst_ret_valid && !data_ret_valid
            && inst_rd_rdy && data_rd_rdy && data_wr_rdy)
        else begin $error("control outputs not at reset values"); fail_count++; end

endmodule

bind cache_axi_bridge cache_axi_bridge_assertions protocol_checks (.*);

`default_nettype wire

//--- test/cache_axi_bridge_tb.sv
`default_nettype none

module cache_axi_bridge_tb import cache_axi_pkg::*; ();

    logic              aclk;
    logic              rst_n;
    logic              inst_rd_req;
    rd_req_t           inst_rd;
    logic              inst_rd_rdy;
    logic              inst_ret_valid;
    logic [line_w-1:0] inst_ret_data;
    logic              data_rd_req;
    rd_req_t           data_rd;
    logic              data_rd_rdy;
    logic              data_ret_valid;
    logic [line_w-1:0] data_ret_data;
    logic              data_wr_req;
    wr_req_t           data_wr;
    logic              data_wr_rdy;
    axi_ar_t           ar;
    logic              arvalid;
    logic              arready;
    axi_r_t            r;
    logic              rvalid;
    logic              rready;
    axi_ar_t           aw;
    logic              awvalid;
    logic              awready;
    axi_w_t            w;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    logic              bready;

    logic [data_w-1:0] mem [logic [addr_w-1:0]];
    axi_ar_t           exp_ar_q [$];
    axi_ar_t           exp_aw_q [$];
    axi_w_t            exp_w_q [$];
    int                errors = 0;
    int                writes_open = 0;
    int unsigned       cycles = 0;
    int unsigned       cycle_limit = 4000;
    bit                inst_wait = 1'b0;
    bit                data_wait = 1'b0;

    cache_axi_bridge cache_axi_bridge_inst (.*);

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    // unwritten words read back as their byte address xor a fixed tag
    function automatic logic [data_w-1:0] mem_read(input logic [addr_w-1:0] addr);
        logic [addr_w-1:0] a;
        a = {addr[addr_w-1:2], 2'b00};
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic void store_word(input logic [addr_w-1:0] addr,
                                       input logic [data_w-1:0] data, input logic [3:0] strb);
        logic [data_w-1:0] word;
        word = mem_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[{addr[addr_w-1:2], 2'b00}] = word;
    endfunction

    function automatic logic [line_w-1:0] line_pattern(input logic [addr_w-1:0] addr);
        logic [line_w-1:0] line;
        for (int k = 0; k < line_beats; k++) begin
            line[data_w*k +: data_w] = mem_read({addr[addr_w-1:4], 4'h0} + addr_w'(4 * k));
        end
        return line;
    endfunction

    function automatic axi_ar_t addr_channel(input logic [id_w-1:0] id, input req_type_t kind,
                                             input logic [addr_w-1:0] addr);
        axi_ar_t a;
        a.id   = id;
        a.addr = (kind == type_line) ? {addr[addr_w-1:4], 4'h0} : addr;
        a.len  = (kind == type_line) ? 8'd3 : 8'd0;
        a.size = (kind == type_line) ? 3'd2 : kind;
        return a;
    endfunction

    task automatic expect_equal(input string name, input logic [line_w-1:0] expected,
                                input logic [line_w-1:0] actual);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic inst_read(input req_type_t kind, input logic [addr_w-1:0] addr,
                             input logic [line_w-1:0] expected);
        inst_rd     = {kind, addr};
        inst_rd_req = 1'b1;
        inst_wait   = 1'b1;
        @(posedge aclk);
        while (!inst_rd_rdy) begin
            @(posedge aclk);
        end
        #1 inst_rd_req = 1'b0;
        @(posedge aclk);
        while (!inst_ret_valid) begin
            @(posedge aclk);
        end
        expect_equal("inst_ret_data", expected, inst_ret_data);
        #1 inst_wait = 1'b0;
    endtask

    task automatic data_read(input req_type_t kind, input logic [addr_w-1:0] addr,
                             input logic [line_w-1:0] expected);
        data_rd     = {kind, addr};
        data_rd_req = 1'b1;
        data_wait   = 1'b1;
        @(posedge aclk);
        while (!data_rd_rdy) begin
            @(posedge aclk);
        end
        #1 data_rd_req = 1'b0;
        @(posedge aclk);
        while (!data_ret_valid) begin
            @(posedge aclk);
        end
        expect_equal("data_ret_data", expected, data_ret_data);
        #1 data_wait = 1'b0;
    endtask

    // returns once the write is accepted, not when it completes
    task automatic issue_write(input req_type_t kind, input logic [addr_w-1:0] addr,
                               input logic [3:0] strb, input logic [line_w-1:0] data);
        axi_w_t beat;
        int     beats;
        beats = (kind == type_line) ? line_beats : 1;
        exp_aw_q.push_back(addr_channel(id_data, kind, addr));
        for (int k = 0; k < beats; k++) begin
            beat.data = data[data_w*k +: data_w];
            beat.strb = (kind == type_line) ? 4'hf : strb;
            beat.last = (k == beats - 1);
            exp_w_q.push_back(beat);
        end
        data_wr     = {kind, addr, strb, data};
        data_wr_req = 1'b1;
        @(posedge aclk);
        while (!data_wr_rdy) begin
            @(posedge aclk);
        end
        #1 data_wr_req = 1'b0;
    endtask

    task automatic wait_write_idle();
        @(posedge aclk);
        while (!data_wr_rdy) begin
            @(posedge aclk);
        end
        #1;
    endtask

    task automatic report_results(input bit timed_out);
        int unsigned fails;
        fails = cache_axi_bridge_inst.protocol_checks.fail_count;
        $display("errors: %0d scoreboard, %0d assertion, %0d timeout", errors, fails, timed_out);
        if (errors == 0 && fails == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
    endtask

    // AXI read slave
    initial begin : read_slave
        axi_ar_t req;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            @(posedge aclk);
            if (arvalid && arready) begin
                req = ar;
                if (exp_ar_q.size() == 0) begin
                    $display("unexpected read address at %0t", $time);
                    errors++;
                end else begin
                    expect_equal("ar", line_w'(exp_ar_q.pop_front()), line_w'(req));
                end
                if (req.id == id_data && writes_open != 0) begin
                    $display("data read issued at %0t while a write was still open", $time);
                    errors++;
                end
                #1 arready = 1'b0;
                for (int k = 0; k <= int'(req.len); k++) begin
                    repeat ($urandom_range(0, 2)) begin
                        @(posedge aclk);
                        #1;
                    end
                    rvalid = 1'b1;
                    r.id   = req.id;
                    r.data = mem_read(req.addr + addr_w'(4 * k));
                    r.last = (k == int'(req.len));
                    @(posedge aclk);
                    while (!rready) begin
                        @(posedge aclk);
                    end
                    #1 rvalid = 1'b0;
                end
            end else begin
                #1 arready = ($urandom_range(0, 1) == 1);
            end
        end
    end

    // AXI write slave
    initial begin : write_slave
        axi_ar_t req;
        axi_w_t  beat;
        int      n;
        bit      aw_seen;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            @(posedge aclk);
            if (awvalid && awready) begin
                req = aw;
                writes_open++;
                if (exp_aw_q.size() == 0) begin
                    $display("unexpected write address at %0t", $time);
                    errors++;
                end else begin
                    expect_equal("aw", line_w'(exp_aw_q.pop_front()), line_w'(req));
                end
                #1 awready = 1'b0;
                n = 0;
                while (n <= int'(req.len)) begin
                    wready = ($urandom_range(0, 1) == 1);
                    @(posedge aclk);
                    if (wvalid && wready) begin
                        beat = w;
                        if (exp_w_q.size() == 0) begin
                            $display("unexpected write beat at %0t", $time);
                            errors++;
                        end else begin
                            expect_equal("w", line_w'(exp_w_q.pop_front()), line_w'(beat));
                        end
                        store_word(req.addr + addr_w'(4 * n), beat.data, beat.strb);
                        n++;
                    end
                    #1;
                end
                wready = 1'b0;
                repeat ($urandom_range(0, 3)) begin
                    @(posedge aclk);
                    #1;
                end
                bvalid = 1'b1;
                @(posedge aclk);
                while (!bready) begin
                    @(posedge aclk);
                end
                #1 bvalid = 1'b0;
                writes_open--;
            end else begin
                // AW always waits at least one cycle for awready
                aw_seen = awvalid;
                #1 awready = aw_seen && ($urandom_range(0, 1) == 1);
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if ((inst_ret_valid && !inst_wait) || (data_ret_valid && !data_wait)) begin
            $display("return pulse at %0t reached a client with no read pending", $time);
            errors++;
        end
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            report_results(1'b1);
            $finish;
        end
    end

    initial begin : stimulus
        logic [line_w-1:0] wdata;
        logic [addr_w-1:0] addr;
        void'($urandom(32'h8256_864f));
        rst_n       = 1'b0;
        inst_rd_req = 1'b0;
        inst_rd     = '0;
        data_rd_req = 1'b0;
        data_rd     = '0;
        data_wr_req = 1'b0;
        data_wr     = '0;
        repeat (5) @(posedge aclk);
        #1 rst_n = 1'b1;
        @(posedge aclk);
        expect_equal("valid, ready and rdy outputs", line_w'(10'b00000_00111),
                     line_w'({arvalid, awvalid, wvalid, rready, bready,
                              inst_ret_valid, data_ret_valid,
                              inst_rd_rdy, data_rd_rdy, data_wr_rdy}));
        #1;

        // instruction line from an unaligned address
        exp_ar_q.push_back(addr_channel(id_inst, type_line, 32'h1000_0024));
        inst_read(type_line, 32'h1000_0024, line_pattern(32'h1000_0024));

        // single data reads
        exp_ar_q.push_back(addr_channel(id_data, type_byte, 32'h2000_0013));
        data_read(type_byte, 32'h2000_0013, line_w'(mem_read(32'h2000_0013)));
        exp_ar_q.push_back(addr_channel(id_data, type_half, 32'h2000_0042));
        data_read(type_half, 32'h2000_0042, line_w'(mem_read(32'h2000_0042)));
        exp_ar_q.push_back(addr_channel(id_data, type_word, 32'h2000_0104));
        data_read(type_word, 32'h2000_0104, line_w'(mem_read(32'h2000_0104)));

        // both clients ask in the same cycle and data goes first
        exp_ar_q.push_back(addr_channel(id_data, type_line, 32'h3000_0010));
        exp_ar_q.push_back(addr_channel(id_inst, type_line, 32'h4000_0030));
        fork
            data_read(type_line, 32'h3000_0010, line_pattern(32'h3000_0010));
            inst_read(type_line, 32'h4000_0030, line_pattern(32'h4000_0030));
        join

        wdata = {$urandom, $urandom, $urandom, $urandom};
        issue_write(type_line, 32'h5000_0008, 4'h0, wdata);
        wait_write_idle();
        wdata = {$urandom, $urandom, $urandom, $urandom};
        issue_write(type_half, 32'h5000_0102, 4'b1100, wdata);
        wait_write_idle();

        // read behind an open write sees the new line
        wdata = {$urandom, $urandom, $urandom, $urandom};
        issue_write(type_line, 32'h6000_0020, 4'h0, wdata);
        exp_ar_q.push_back(addr_channel(id_data, type_line, 32'h6000_0020));
        data_read(type_line, 32'h6000_0020, wdata);

        for (int i = 0; i < 24; i++) begin
            addr = $urandom & 32'hffff_fffc;
            if (i % 2 == 0) begin
                exp_ar_q.push_back(addr_channel(id_inst, type_line, addr));
                inst_read(type_line, addr, line_pattern(addr));
            end else begin
                exp_ar_q.push_back(addr_channel(id_data, type_word, addr));
                data_read(type_word, addr, line_w'(mem_read(addr)));
            end
        end

        repeat (3) @(posedge aclk);
        report_results(1'b0);
        $finish;
    end

endmodule

`default_nettype wire
